//--- verilog/rv_core_pkg.sv
package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes, insn[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;  // Register-register ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // Register-immediate ALU
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // funct3 field, insn[14:12]
    localparam logic [2:0] F3_ADD_SUB = 3'b000;  // insn[30] picks sub on OP
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;  // insn[30] picks arithmetic
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_WORD    = 3'b010;  // lw / sw access size

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

endpackage

//--- verilog/instr_mem.sv
module instr_mem
    import rv_core_pkg::*;
#(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                          CLK,
    input  logic                          we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] waddr,
    input  logic [XLEN-1:0]               wdata,
    input  logic [XLEN-1:0]               raddr,
    output logic [XLEN-1:0]               rdata
);

    localparam int AW = $clog2(IMEM_DEPTH);

    logic [XLEN-1:0] mem [IMEM_DEPTH];
    logic [AW-1:0]   ridx;

    // Byte address to word index, wraps at the depth
    assign ridx = raddr[AW+1:2];

    // Program load port, only used while the core is stopped
    always_ff @(posedge CLK) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata = mem[ridx];  // Same-cycle fetch

endmodule

//--- verilog/reg_file.sv
module reg_file
    import rv_core_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RST,
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    input  logic [REG_ADDR_W-1:0] rd,
    input  logic                  we,
    input  logic [XLEN-1:0]       wdata,
    output logic [XLEN-1:0]       rdata1,
    output logic [XLEN-1:0]       rdata2
);

    localparam int NREGS = 1 << REG_ADDR_W;

    logic [XLEN-1:0] regs [NREGS];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wdata;  // x0 never written
        end
    end

    // Reads see the value before this cycle's write lands
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- verilog/instr_decoder.sv
module instr_decoder
    import rv_core_pkg::*;
(
    input  logic [XLEN-1:0]       insn,
    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2,
    output logic [REG_ADDR_W-1:0] rd,
    output logic [XLEN-1:0]       imm,
    output alu_op_e               alu_op,
    output logic                  use_imm,
    output logic                  reg_we,
    output logic                  mem_re,
    output logic                  mem_we
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;

    // ALU operation from funct3; alt is insn[30], which only
    // selects sub on register ops but selects sra on both forms
    function automatic alu_op_e map_alu_op(input logic [2:0] f3,
                                           input logic       alt,
                                           input logic       is_reg);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            F3_AND:     op = ALU_AND;
            default:    op = ALU_ADD;
        endcase
        return op;
    endfunction

    assign opcode = insn[6:0];
    assign funct3 = insn[14:12];
    assign rd     = insn[11:7];
    assign rs1    = insn[19:15];
    assign rs2    = insn[24:20];

    assign imm_i = {{(XLEN-12){insn[31]}}, insn[31:20]};
    assign imm_s = {{(XLEN-12){insn[31]}}, insn[31:25], insn[11:7]};
    assign imm   = (opcode == OPC_STORE) ? imm_s : imm_i;

    always_comb begin
        alu_op  = ALU_ADD;  // Address add for lw / sw
        use_imm = 1'b0;
        reg_we  = 1'b0;
        mem_re  = 1'b0;
        mem_we  = 1'b0;
        case (opcode)
            OPC_OP: begin
                alu_op = map_alu_op(funct3, insn[30], 1'b1);
                reg_we = 1'b1;
            end
            OPC_OP_IMM: begin
                alu_op  = map_alu_op(funct3, insn[30], 1'b0);
                use_imm = 1'b1;
                reg_we  = 1'b1;
            end
            OPC_LOAD: begin
                use_imm = 1'b1;
                if (funct3 == F3_WORD) begin  // Byte/half loads unsupported
                    reg_we = 1'b1;
                    mem_re = 1'b1;
                end
            end
            OPC_STORE: begin
                use_imm = 1'b1;
                mem_we  = (funct3 == F3_WORD);
            end
            default: ;  // Retires with no side effect
        endcase
        if (rd == '0) begin
            reg_we = 1'b0;
        end
    end

endmodule

//--- verilog/alu.sv
module alu
    import rv_core_pkg::*;
(
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  alu_op_e         op,
    output logic [XLEN-1:0] y
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];  // RV32 shift range
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            ALU_ADD:  y = a + b;
            ALU_SUB:  y = a - b;
            ALU_SLL:  y = a << shamt;
            ALU_SLT:  y = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: y = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:  y = a ^ b;
            ALU_SRL:  y = a >> shamt;
            ALU_SRA:  y = $unsigned($signed(a) >>> shamt);  // Sign fill
            ALU_OR:   y = a | b;
            ALU_AND:  y = a & b;
            default:  y = '0;
        endcase
    end

endmodule

//--- verilog/data_mem.sv
module data_mem
    import rv_core_pkg::*;
#(
    parameter int DMEM_DEPTH = 64
) (
    input  logic            CLK,
    input  logic            RST,
    input  logic [XLEN-1:0] addr,
    input  logic            we,
    input  logic [XLEN-1:0] wdata,
    output logic [XLEN-1:0] rdata
);

    localparam int AW = $clog2(DMEM_DEPTH);

    logic [XLEN-1:0] mem [DMEM_DEPTH];
    logic [AW-1:0]   idx;

    assign idx = addr[AW+1:2];  // Word index, modulo depth

    // Cleared so a load from an unwritten word returns zero
    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = mem[idx];

endmodule

//--- verilog/single_cycle_core.sv
module single_cycle_core
    import rv_core_pkg::*;
#(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 64
) (
    input  logic                          CLK,
    input  logic                          RST,
    input  logic                          run,
    input  logic                          imem_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
    input  logic [XLEN-1:0]               imem_wdata,
    output logic                          retire_valid,
    output logic [XLEN-1:0]               retire_pc,
    output logic [XLEN-1:0]               retire_insn,
    output logic [REG_ADDR_W-1:0]         retire_rd,
    output logic [XLEN-1:0]               retire_wdata
);

    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       insn;

    // Decoder outputs
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm;
    alu_op_e               alu_op;
    logic                  use_imm;
    logic                  reg_we;
    logic                  mem_re;
    logic                  mem_we;

    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       alu_b;
    logic [XLEN-1:0]       alu_y;
    logic [XLEN-1:0]       dmem_rdata;
    logic [XLEN-1:0]       wb_data;

    // One instruction per run cycle, no stalls
    always_ff @(posedge CLK) begin
        if (RST) begin
            pc <= '0;
        end else if (run) begin
            pc <= pc + XLEN'(4);
        end
    end

    instr_mem #(
        .IMEM_DEPTH(IMEM_DEPTH)
    ) imem_i (
        .CLK  (CLK),
        .we   (imem_we),
        .waddr(imem_addr),
        .wdata(imem_wdata),
        .raddr(pc),
        .rdata(insn)
    );

    instr_decoder dec_i (
        .insn   (insn),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .imm    (imm),
        .alu_op (alu_op),
        .use_imm(use_imm),
        .reg_we (reg_we),
        .mem_re (mem_re),
        .mem_we (mem_we)
    );

    reg_file rf_i (
        .CLK   (CLK),
        .RST   (RST),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd),
        .we    (reg_we && run),
        .wdata (wb_data),
        .rdata1(rs1_data),
        .rdata2(rs2_data)
    );

    assign alu_b = use_imm ? imm : rs2_data;  // Immediate for all but R-type

    alu alu_i (
        .a (rs1_data),
        .b (alu_b),
        .op(alu_op),
        .y (alu_y)
    );

    data_mem #(
        .DMEM_DEPTH(DMEM_DEPTH)
    ) dmem_i (
        .CLK  (CLK),
        .RST  (RST),
        .addr (alu_y),
        .we   (mem_we && run),
        .wdata(rs2_data),
        .rdata(dmem_rdata)
    );

    assign wb_data = mem_re ? dmem_rdata : alu_y;

    // Retire trace, describes the instruction executing this cycle
    assign retire_valid = run;
    assign retire_pc    = pc;
    assign retire_insn  = insn;
    assign retire_rd    = reg_we ? rd : '0;  // Zero when nothing is written
    assign retire_wdata = (retire_rd != '0) ? wb_data : '0;

endmodule

//--- dv/tb_clk_gen.sv
module tb_clk_gen #(
    parameter int PERIOD = 20
) (
    output logic CLK
);

    initial begin
        CLK = 1'b0;
        forever begin
            #(PERIOD / 2) CLK = ~CLK;
        end
    end

endmodule

//--- dv/core_tb.sv
module core_tb
    import rv_core_pkg::*;
();

    localparam int IMEM_DEPTH    = 256;
    localparam int DMEM_DEPTH    = 64;
    localparam int IMEM_AW       = $clog2(IMEM_DEPTH);
    localparam int PROG_LEN      = 200;
    localparam int RESET_CYCLES  = 2;
    localparam int PAUSE_AT      = 100;
    localparam int PAUSE_CYCLES  = 5;
    localparam int DRIVE_DLY     = 2;
    localparam int MARGIN_CYCLES = 193;  // Slack on top of reset, load, run and pause
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * PROG_LEN + PAUSE_CYCLES + MARGIN_CYCLES;

    logic                  CLK;
    logic                  RST;
    logic                  run;
    logic                  imem_we;
    logic [IMEM_AW-1:0]    imem_addr;
    logic [XLEN-1:0]       imem_wdata;
    logic                  retire_valid;
    logic [XLEN-1:0]       retire_pc;
    logic [XLEN-1:0]       retire_insn;
    logic [REG_ADDR_W-1:0] retire_rd;
    logic [XLEN-1:0]       retire_wdata;

    integer          seed;
    int              cycle_count;
    logic [XLEN-1:0] prog [PROG_LEN];
    logic [XLEN-1:0] model_regs [32];
    logic [XLEN-1:0] model_dmem [DMEM_DEPTH];
    logic [XLEN-1:0] model_pc;

    tb_clk_gen #(.PERIOD(20)) clk_gen_i (.CLK(CLK));

    single_cycle_core #(
        .IMEM_DEPTH(IMEM_DEPTH),
        .DMEM_DEPTH(DMEM_DEPTH)
    ) dut_i (
        .CLK         (CLK),
        .RST         (RST),
        .run         (run),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .retire_valid(retire_valid),
        .retire_pc   (retire_pc),
        .retire_insn (retire_insn),
        .retire_rd   (retire_rd),
        .retire_wdata(retire_wdata)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [XLEN-1:0] exp,
                                   input logic [XLEN-1:0] act);
        $display("ERR %s expected=%h actual=%h (pc %h)", name, exp, act, model_pc);
        abort_run("retire trace differs from the model");
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [XLEN-1:0] r_type_word(input logic [6:0] f7, input int rs2,
                                                    input int rs1, input logic [2:0] f3,
                                                    input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
    endfunction

    function automatic logic [XLEN-1:0] i_type_word(input logic [11:0] imm, input int rs1,
                                                    input logic [2:0] f3, input int rd,
                                                    input logic [6:0] opc);
        return {imm, rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [XLEN-1:0] s_type_word(input logic [11:0] imm, input int rs2,
                                                    input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], F3_WORD, imm[4:0], OPC_STORE};
    endfunction

    // Register setup, a known empty-word load, then random mix
    task automatic build_program();
        int          i;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic        alt;
        for (i = 1; i < 16; i++) begin
            imm = $random(seed);
            imm[11] = i[0];  // Odd registers get negative values
            prog[i - 1] = i_type_word(imm, 0, F3_ADD_SUB, i, OPC_OP_IMM);
        end
        prog[15] = i_type_word(12'h123, 1, F3_ADD_SUB, 0, OPC_OP_IMM);  // Write to x0
        prog[16] = i_type_word(12'((DMEM_DEPTH - 1) * 4), 0, F3_WORD, 16, OPC_LOAD);
        i = 17;
        while (i < PROG_LEN) begin
            f3  = $random(seed);
            alt = $random(seed);
            imm = $random(seed);
            if (rand_below(8) == 0) begin
                prog[i] = $random(seed);  // Mostly unsupported opcodes
            end else begin
                case (rand_below(4))
                    0: prog[i] = r_type_word((f3 == 3'b000 || f3 == 3'b101) ? {1'b0, alt, 5'b0}
                                             : 7'b0, rand_below(32), rand_below(32), f3,
                                             rand_below(32));
                    3: begin
                        imm = 12'(rand_below(DMEM_DEPTH) * 4);
                        if (i < PROG_LEN - 1) begin
                            prog[i] = s_type_word(imm, rand_below(32), 0);
                            i++;
                        end
                        prog[i] = i_type_word(imm, 0, F3_WORD, rand_below(32), OPC_LOAD);
                    end
                    default: begin
                        if (f3 == F3_SLL) begin
                            imm[11:5] = 7'b0;
                        end else if (f3 == F3_SRL_SRA) begin
                            imm[11:5] = {1'b0, alt, 5'b0};
                        end
                        prog[i] = i_type_word(imm, rand_below(32), f3, rand_below(32),
                                              OPC_OP_IMM);
                    end
                endcase
            end
            i++;
        end
    endtask

    // RV32I integer semantics with alt as instruction bit 30
    function automatic logic [XLEN-1:0] alu_result(input logic [2:0] f3, input logic alt,
                                                   input logic is_reg,
                                                   input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
        case (f3)
            3'b000:  return (alt && is_reg) ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 1 : 0;
            3'b011:  return (a < b) ? 1 : 0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? XLEN'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic step_model(input logic [XLEN-1:0] word, output logic [REG_ADDR_W-1:0] rd,
                              output logic [XLEN-1:0] value);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] imm_s;
        logic            writes;
        a      = model_regs[word[19:15]];
        b      = model_regs[word[24:20]];
        imm_i  = {{20{word[31]}}, word[31:20]};
        imm_s  = {{20{word[31]}}, word[31:25], word[11:7]};
        writes = 1'b0;
        value  = '0;
        case (word[6:0])
            OPC_OP: begin
                value  = alu_result(word[14:12], word[30], 1'b1, a, b);
                writes = 1'b1;
            end
            OPC_OP_IMM: begin
                value  = alu_result(word[14:12], word[30], 1'b0, a, imm_i);
                writes = 1'b1;
            end
            OPC_LOAD: if (word[14:12] == F3_WORD) begin
                value  = model_dmem[((a + imm_i) >> 2) % DMEM_DEPTH];
                writes = 1'b1;
            end
            OPC_STORE: if (word[14:12] == F3_WORD) begin
                model_dmem[((a + imm_s) >> 2) % DMEM_DEPTH] = b;
            end
            default: ;
        endcase
        rd = writes ? word[11:7] : '0;  // x0 destination counts as no write
        if (rd == '0) begin
            value = '0;
        end else begin
            model_regs[rd] = value;
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < PROG_LEN; i++) begin
            imem_we    = 1'b1;
            imem_addr  = i[IMEM_AW-1:0];
            imem_wdata = prog[i];
            @(negedge CLK);
            assert (retire_valid === 1'b0)
                else report_mismatch("valid low during load", 0, retire_valid);
            assert (retire_pc === model_pc)
                else report_mismatch("pc at reset value", model_pc, retire_pc);
            @(posedge CLK);
            #DRIVE_DLY;
        end
        imem_we = 1'b0;
    endtask

    task automatic execute_cycles(input int count);
        logic [REG_ADDR_W-1:0] exp_rd;
        logic [XLEN-1:0]       exp_wdata;
        logic [XLEN-1:0]       word;
        for (int n = 0; n < count; n++) begin
            run = 1'b1;
            @(negedge CLK);  // Retire outputs settled here
            word = prog[model_pc >> 2];
            assert (retire_valid === 1'b1)
                else report_mismatch("valid high while running", 1, retire_valid);
            assert (retire_pc === model_pc) else report_mismatch("retire_pc", model_pc, retire_pc);
            assert (retire_insn === word) else report_mismatch("retire_insn", word, retire_insn);
            step_model(word, exp_rd, exp_wdata);
            assert (retire_rd === exp_rd) else report_mismatch("retire_rd", exp_rd, retire_rd);
            assert (retire_wdata === exp_wdata)
                else report_mismatch("retire_wdata", exp_wdata, retire_wdata);
            model_pc = model_pc + 4;
            @(posedge CLK);
            #DRIVE_DLY;
        end
    endtask

    task automatic hold_cycles(input int count);
        for (int n = 0; n < count; n++) begin
            run = 1'b0;
            @(negedge CLK);
            assert (retire_valid === 1'b0)
                else report_mismatch("valid low while stopped", 0, retire_valid);
            assert (retire_pc === model_pc)
                else report_mismatch("pc hold while stopped", model_pc, retire_pc);
            @(posedge CLK);
            #DRIVE_DLY;
        end
    endtask

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run("Timeout, the test did not finish within the cycle limit");
        end
    end

    initial begin
        seed        = 32'h3a9bbf28;
        cycle_count = 0;
        RST         = 1'b1;
        run         = 1'b0;
        imem_we     = 1'b0;
        imem_addr   = '0;
        imem_wdata  = '0;
        model_pc    = '0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        for (int w = 0; w < DMEM_DEPTH; w++) begin
            model_dmem[w] = '0;
        end
        build_program();
        repeat (RESET_CYCLES) @(posedge CLK);
        #DRIVE_DLY;
        RST = 1'b0;
        load_program();
        execute_cycles(PAUSE_AT);
        hold_cycles(PAUSE_CYCLES);  // Stop mid-program and expect pc to hold
        execute_cycles(PROG_LEN - PAUSE_AT);
        run = 1'b0;
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- verilog.f
verilog/rv_core_pkg.sv
verilog/instr_mem.sv
verilog/reg_file.sv
verilog/instr_decoder.sv
verilog/alu.sv
verilog/data_mem.sv
verilog/single_cycle_core.sv
dv/tb_clk_gen.sv
dv/core_tb.sv

//--- Bender.yml
package:
  name: single_cycle_core

sources:
  - files:
      - verilog/rv_core_pkg.sv
      - verilog/instr_mem.sv
      - verilog/reg_file.sv
      - verilog/instr_decoder.sv
      - verilog/alu.sv
      - verilog/data_mem.sv
      - verilog/single_cycle_core.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/core_tb.sv
